// ==== hdl/crc_pkg.sv ====
// CRC peripheral shared definitions
// Register map, AHB encodings, control word layout and internal bus structs
package crc_pkg;

	////////////////////////////////////////////////////////////
	// Register map, word index taken from HADDR[4:2]
	////////////////////////////////////////////////////////////
	localparam logic [2:0] crc_dr_addr   = 3'h0;
	localparam logic [2:0] crc_idr_addr  = 3'h1;
	localparam logic [2:0] crc_cr_addr   = 3'h2;
	localparam logic [2:0] crc_init_addr = 3'h4;
	localparam logic [2:0] crc_pol_addr  = 3'h5;

	// Engine register values after reset
	localparam logic [31:0] crc_poly_reset = 32'h04C1_1DB7;
	localparam logic [31:0] crc_init_reset = 32'hFFFF_FFFF;

	////////////////////////////////////////////////////////////
	// AHB encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {htrans_idle, htrans_busy, htrans_nonseq, htrans_seq} htrans_t;

	// Only the sizes up to a word are supported
	typedef enum logic [1:0] {size_byte, size_half, size_word} hsize_t;

	////////////////////////////////////////////////////////////
	// Control fields
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {poly_32, poly_16, poly_8, poly_7} poly_size_t;
	typedef enum logic [1:0] {rev_none, rev_byte, rev_half, rev_word} rev_in_t;

	// Configuration seen by the buffer and the engine
	typedef struct packed {
		poly_size_t poly_size;
		rev_in_t    rev_in;
		logic       rev_out;
	} crc_cfg_t;

	// Control register layout, MSB first
	typedef struct packed {
		logic [23:0] zero;
		logic        rev_out;
		rev_in_t     rev_in;
		poly_size_t  poly_size;
		logic [1:0]  unused;
		logic        restart;
	} crc_cr_fields_t;

	// Control word, seen as raw bits or as fields
	typedef union packed {
		logic [31:0]    raw;
		crc_cr_fields_t f;
	} crc_cr_word_u;

	// Data register write handed to the input buffer
	typedef struct packed {
		logic [31:0] data;
		hsize_t      size;
	} crc_wr_t;

endpackage

// ==== hdl/host_interface.sv ====
// AHB-Lite slave port of the CRC peripheral
// Pipelines the address phase, decodes registers, holds the control register
// and inserts wait states on buffer and restart back-pressure
`timescale 1ns/1ps

module host_interface
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	input  logic [31:0] crc_out,
	input  logic [31:0] crc_init_out,
	input  logic [31:0] crc_poly_out,
	input  logic [7:0]  crc_idr_out,
	input  logic        buffer_full,
	input  logic        read_wait,
	input  logic        reset_pending,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	output crc_wr_t     bus_wr,
	output logic [31:0] bus_data,
	output logic        buffer_write_en,
	output logic        crc_init_en,
	output logic        crc_idr_en,
	output logic        crc_poly_en,
	output logic        reset_chain,
	output crc_cfg_t    crc_cfg
);

	// Address phase pipeline
	logic [2:0]   haddr_pp;
	hsize_t       hsize_pp;
	htrans_t      htrans_pp;
	logic         hwrite_pp;
	logic         hselx_pp;

	logic         sample_bus;
	logic         write_en;
	logic         read_en;
	logic         crc_cr_en;
	logic         buffer_read_en;
	crc_cr_word_u cr_wdata;
	crc_cr_word_u cr_rdata;

	////////////////////////////////////////////////////////////
	// Address phase
	////////////////////////////////////////////////////////////

	// Bus is sampled only when no wait state is pending
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			haddr_pp  <= crc_dr_addr;
			hsize_pp  <= size_word;
			htrans_pp <= htrans_idle;
			hwrite_pp <= 1'b0;
			hselx_pp  <= 1'b0;
		end
		else if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			// Sizes above a word clamp to a word
			hsize_pp  <= HSIZE[2] ? size_word : hsize_t'(HSIZE[1:0]);
			htrans_pp <= htrans_t'(HTRANS);
			hwrite_pp <= HWRITE;
			hselx_pp  <= HSElx;
		end
	end

	////////////////////////////////////////////////////////////
	// Register decode
	////////////////////////////////////////////////////////////

	// Only NONSEQ transfers act, SEQ and BUSY are ignored
	assign write_en = hselx_pp && hwrite_pp && (htrans_pp == htrans_nonseq);
	assign read_en  = hselx_pp && !hwrite_pp && (htrans_pp == htrans_nonseq);

	assign buffer_write_en = write_en && (haddr_pp == crc_dr_addr);
	assign crc_init_en     = write_en && (haddr_pp == crc_init_addr);
	assign crc_idr_en      = write_en && (haddr_pp == crc_idr_addr);
	assign crc_poly_en     = write_en && (haddr_pp == crc_pol_addr);
	assign crc_cr_en       = write_en && (haddr_pp == crc_cr_addr);
	assign buffer_read_en  = read_en && (haddr_pp == crc_dr_addr);

	// Write data is used unregistered in the data phase
	assign bus_data = HWDATA;
	assign bus_wr   = '{data: HWDATA, size: hsize_pp};

	////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////

	always_comb
	begin
		cr_wdata.raw = HWDATA;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cfg <= '0;
		else if (crc_cr_en)
			crc_cfg <= '{poly_size: cr_wdata.f.poly_size,
				rev_in: cr_wdata.f.rev_in,
				rev_out: cr_wdata.f.rev_out};
	end

	// Bit 0 is a self-clearing restart
	assign reset_chain = crc_cr_en && cr_wdata.f.restart;

	// Read view, restart and unused bits return zero
	always_comb
	begin
		cr_rdata.raw         = '0;
		cr_rdata.f.poly_size = crc_cfg.poly_size;
		cr_rdata.f.rev_in    = crc_cfg.rev_in;
		cr_rdata.f.rev_out   = crc_cfg.rev_out;
	end

	////////////////////////////////////////////////////////////
	// Read mux and response
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (haddr_pp)
			crc_dr_addr:   HRDATA = crc_out;
			crc_idr_addr:  HRDATA = {24'h0, crc_idr_out};
			crc_cr_addr:   HRDATA = cr_rdata.raw;
			crc_init_addr: HRDATA = crc_init_out;
			crc_pol_addr:  HRDATA = crc_poly_out;
			default:       HRDATA = '0;
		endcase
	end

	// Stall on full buffer, unfinished CRC, or init write during a restart
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
		(buffer_read_en && read_wait) ||
		(crc_init_en && reset_pending));

	// Always OKAY
	assign HRESP = 1'b0;

	// Stalls only come from this slave's data phase, so the bus must wait too
	a_hready_follows: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!HREADYOUT |-> !HREADY);

endmodule

// ==== hdl/crc_input_buffer.sv ====
// CRC input buffer
// Holds one written word, bit-reversed as configured, and feeds it out bytewise
`timescale 1ns/1ps

module crc_input_buffer
	import crc_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  crc_wr_t    bus_wr,
	input  logic       buffer_write_en,
	input  crc_cfg_t   crc_cfg,
	output logic       buffer_full,
	output logic       read_wait,
	output logic       byte_valid,
	output logic [7:0] byte_data
);

	logic [31:0] data_ff;
	logic [2:0]  count_ff;
	logic        accept;
	logic [2:0]  wr_count;
	rev_in_t     rev_span;
	logic [31:0] rev_b;
	logic [31:0] rev_h;
	logic [31:0] rev_w;
	logic [31:0] data_in;

	////////////////////////////////////////////////////////////
	// Input reversal
	////////////////////////////////////////////////////////////

	// All three reversal spans, picked below
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			rev_b[i] = bus_wr.data[(i / 8) * 8 + 7 - (i % 8)];
			rev_h[i] = bus_wr.data[(i / 16) * 16 + 15 - (i % 16)];
			rev_w[i] = bus_wr.data[31 - i];
		end
	end

	always_comb
	begin
		rev_span = crc_cfg.rev_in;
		// Reversal span is capped at the written size so data stays in the low bytes
		if (bus_wr.size == size_byte && rev_span != rev_none)
			rev_span = rev_byte;
		else if (bus_wr.size == size_half && rev_span == rev_word)
			rev_span = rev_half;
		case (rev_span)
			rev_byte: data_in = rev_b;
			rev_half: data_in = rev_h;
			rev_word: data_in = rev_w;
			default:  data_in = bus_wr.data;
		endcase
	end

	// Bytes to process for this write
	always_comb
	begin
		case (bus_wr.size)
			size_byte: wr_count = 3'd1;
			size_half: wr_count = 3'd2;
			default:   wr_count = 3'd4;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Byte shifter
	////////////////////////////////////////////////////////////

	assign accept = buffer_write_en && !buffer_full;

	// Count of bytes still to go, LSB byte first
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_ff <= '0;
		else if (accept)
			count_ff <= wr_count;
		else if (count_ff != 3'd0)
			count_ff <= count_ff - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (accept)
			data_ff <= data_in;
		else if (count_ff != 3'd0)
			data_ff <= data_ff >> 8;
	end

	assign buffer_full = (count_ff != 3'd0);
	assign read_wait   = buffer_full;
	assign byte_valid  = buffer_full;
	assign byte_data   = data_ff[7:0];

	// A stalled write stays on the bus until taken, so none is dropped
	a_write_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(buffer_write_en && buffer_full) |=> buffer_write_en);

endmodule

// ==== hdl/crc_engine.sv ====
// CRC engine
// Keeps polynomial, initial value, scratch byte and CRC state, one byte per clock
`timescale 1ns/1ps

module crc_engine
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] bus_data,
	input  logic        crc_init_en,
	input  logic        crc_poly_en,
	input  logic        crc_idr_en,
	input  logic        reset_chain,
	input  crc_cfg_t    crc_cfg,
	input  logic        byte_valid,
	input  logic [7:0]  byte_data,
	output logic [31:0] crc_out,
	output logic [31:0] crc_init_out,
	output logic [31:0] crc_poly_out,
	output logic [7:0]  crc_idr_out,
	output logic        reset_pending
);

	logic [31:0] crc_ff;
	logic [31:0] width_mask;
	logic [4:0]  rev_shift;
	logic [31:0] crc_masked;
	logic [31:0] crc_rev;

	// Eight MSB-first shift and XOR steps, feedback taken at the top of the width
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [31:0] poly,
		input logic [7:0] data, input poly_size_t size);
		logic [31:0] c;
		logic        top;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			case (size)
				poly_16: top = c[15];
				poly_8:  top = c[7];
				poly_7:  top = c[6];
				default: top = c[31];
			endcase
			c = c << 1;
			if (top ^ data[i])
				c = c ^ poly;
		end
		return c;
	endfunction

	// Width mask and shift that right-aligns a reversed state
	always_comb
	begin
		case (crc_cfg.poly_size)
			poly_16: width_mask = 32'h0000_FFFF;
			poly_8:  width_mask = 32'h0000_00FF;
			poly_7:  width_mask = 32'h0000_007F;
			default: width_mask = 32'hFFFF_FFFF;
		endcase
		case (crc_cfg.poly_size)
			poly_16: rev_shift = 5'd16;
			poly_8:  rev_shift = 5'd24;
			poly_7:  rev_shift = 5'd25;
			default: rev_shift = 5'd0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_poly_out  <= crc_poly_reset;
			crc_init_out  <= crc_init_reset;
			crc_idr_out   <= '0;
			reset_pending <= 1'b0;
		end
		else
		begin
			if (crc_poly_en)
				crc_poly_out <= bus_data;
			// Init write held off while the reload uses the old value
			if (crc_init_en && !reset_pending)
				crc_init_out <= bus_data;
			if (crc_idr_en)
				crc_idr_out <= bus_data[7:0];
			reset_pending <= reset_chain;
		end
	end

	// CRC state, restart takes priority over data
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_ff <= crc_init_reset;
		else if (reset_pending)
			crc_ff <= crc_init_out;
		else if (byte_valid)
			crc_ff <= crc_byte(crc_ff, crc_poly_out, byte_data, crc_cfg.poly_size) & width_mask;
	end

	////////////////////////////////////////////////////////////
	// Output reversal
	////////////////////////////////////////////////////////////

	assign crc_masked = crc_ff & width_mask;

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			crc_rev[i] = crc_masked[31 - i];
	end

	assign crc_out = crc_cfg.rev_out ? (crc_rev >> rev_shift) : crc_masked;

	// Restart is only issued once the buffer has drained
	a_no_restart_on_data: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(byte_valid && reset_chain));

endmodule

// ==== hdl/crc_ahb.sv ====
// CRC peripheral with AHB-Lite slave port
// Joins the host interface, the input buffer and the CRC engine
`timescale 1ns/1ps

module crc_ahb
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	crc_wr_t     bus_wr;
	crc_cfg_t    crc_cfg;
	logic [31:0] bus_data;
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;
	logic        buffer_full;
	logic        read_wait;
	logic        reset_pending;
	logic        byte_valid;
	logic [7:0]  byte_data;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;

	host_interface i_host_interface (.*);

	crc_input_buffer i_crc_input_buffer (.*);

	crc_engine i_crc_engine (.*);

endmodule

// ==== tests/tb_crc_ahb.sv ====
// Testbench for the CRC peripheral with AHB-Lite slave port
// Checks registers, CRC widths, reversal, bus stalls and restart against a model
`timescale 1ns/1ps

module tb_crc_ahb
	import crc_pkg::*;
();

	// Longest stall allowed on any bus phase
	localparam int timeout_cycles = 200;

	logic        HCLK = 1'b0;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic        HREADY;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Reference model state
	logic [31:0] model_crc;
	logic [31:0] model_poly;
	int          model_width;
	logic [1:0]  model_rev_in;
	logic        model_rev_out;
	logic [31:0] lcg_state;

	// 8 ns clock
	always #4 HCLK = ~HCLK;

	// Single slave on the bus, so HREADY follows HREADYOUT
	assign HREADY = HREADYOUT;

	crc_ahb i_crc_ahb (.*);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] random_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		if (w == 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << w) - 32'h1;
	endfunction

	// One byte, MSB first, feedback from the top bit of the active width
	function automatic logic [31:0] model_byte(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		logic [31:0] m;
		logic [4:0]  top_bit;
		logic        fb;
		c = crc;
		m = width_mask(model_width);
		top_bit = 5'(model_width - 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[top_bit] ^ b[3'(i)];
			c = (c << 1) & m;
			if (fb)
				c = c ^ (model_poly & m);
		end
		return c;
	endfunction

	// Bit reversal in chunks of the chosen span, never wider than the write
	function automatic logic [31:0] reverse_chunks(input logic [31:0] d, input int nbytes);
		logic [31:0] r;
		int          span;
		case (model_rev_in)
			2'd1:    span = 8;
			2'd2:    span = 16;
			2'd3:    span = 32;
			default: span = 0;
		endcase
		if (span > nbytes * 8)
			span = nbytes * 8;
		if (span == 0)
			return d;
		r = d;
		for (int i = 0; i < nbytes * 8; i++)
			r[5'(i)] = d[5'((i / span) * span + span - 1 - (i % span))];
		return r;
	endfunction

	// Readable CRC, reflected over the width when output reversal is on
	function automatic logic [31:0] expected_crc();
		logic [31:0] r;
		r = '0;
		if (!model_rev_out)
			return model_crc;
		for (int i = 0; i < model_width; i++)
			r[5'(i)] = model_crc[5'(model_width - 1 - i)];
		return r;
	endfunction

	// Low byte goes in first
	task automatic model_feed(input logic [31:0] data, input int nbytes);
		logic [31:0] d;
		d = reverse_chunks(data, nbytes);
		for (int i = 0; i < nbytes; i++)
			model_crc = model_byte(model_crc, 8'(d >> (8 * i)));
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("** Error %s: expected %08h, actual %08h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// AHB master tasks, entered 1 ns after a rising edge
	////////////////////////////////////////////////////////////

	// Ends the current phase, HRDATA taken mid cycle of its last cycle
	task automatic wait_ready(output logic [31:0] rdata);
		int cycles;
		cycles = 0;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			cycles++;
			if (cycles > timeout_cycles)
			begin
				$display("Timeout: HREADYOUT stayed low for %0d cycles", cycles);
				$display("TEST FAILED");
				$fatal(1, "Bus transfer never completed");
			end
			@(negedge HCLK);
		end
		rdata = HRDATA;
		// Every completed phase answers OKAY
		check_value("hresp okay", 32'h0, {31'h0, HRESP});
		@(posedge HCLK);
		#1;
	endtask

	task automatic drive_addr(input logic [2:0] reg_addr, input logic write, input int nbytes);
		HSElx  = 1'b1;
		HADDR  = {27'h0, reg_addr, 2'b00};
		HTRANS = htrans_nonseq;
		HWRITE = write;
		HSIZE  = (nbytes == 1) ? 3'd0 : (nbytes == 2) ? 3'd1 : 3'd2;
	endtask

	task automatic drive_idle();
		HSElx  = 1'b0;
		HTRANS = htrans_idle;
		HWRITE = 1'b0;
	endtask

	task automatic bus_write(input logic [2:0] reg_addr, input logic [31:0] data,
		input int nbytes);
		logic [31:0] unused_rdata;
		drive_addr(reg_addr, 1'b1, nbytes);
		wait_ready(unused_rdata);
		HWDATA = data;
		drive_idle();
		wait_ready(unused_rdata);
	endtask

	task automatic read_and_check(input logic [2:0] reg_addr, input string name,
		input logic [31:0] expected);
		logic [31:0] unused_rdata;
		logic [31:0] rdata;
		drive_addr(reg_addr, 1'b0, 4);
		wait_ready(unused_rdata);
		drive_idle();
		wait_ready(rdata);
		check_value(name, expected, rdata);
	endtask

	task automatic data_write(input logic [31:0] data, input int nbytes);
		bus_write(crc_dr_addr, data, nbytes);
		model_feed(data, nbytes);
	endtask

	// Polynomial, initial value, then control word with restart
	task automatic set_mode(input logic [31:0] poly, input logic [31:0] init,
		input logic [1:0] size_code, input logic [1:0] rev_in, input logic rev_out);
		bus_write(crc_pol_addr, poly, 4);
		bus_write(crc_init_addr, init, 4);
		bus_write(crc_cr_addr, {24'h0, rev_out, rev_in, size_code, 2'b00, 1'b1}, 4);
		case (size_code)
			2'd1:    model_width = 16;
			2'd2:    model_width = 8;
			2'd3:    model_width = 7;
			default: model_width = 32;
		endcase
		model_poly    = poly;
		model_rev_in  = rev_in;
		model_rev_out = rev_out;
		model_crc     = init & width_mask(model_width);
	endtask

	// Pipelined word writes, the DR read issued in the last write's data phase
	task automatic burst_then_read(input int count, output logic [31:0] rdata);
		logic [31:0] data;
		logic [31:0] unused_rdata;
		drive_addr(crc_dr_addr, 1'b1, 4);
		wait_ready(unused_rdata);
		for (int i = 0; i < count; i++)
		begin
			data = random_word();
			HWDATA = data;
			if (i == count - 1)
				drive_addr(crc_dr_addr, 1'b0, 4);
			else
				drive_addr(crc_dr_addr, 1'b1, 4);
			wait_ready(unused_rdata);
			model_feed(data, 4);
		end
		drive_idle();
		wait_ready(rdata);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		HRESETn   = 1'b0;
		HSElx     = 1'b0;
		HADDR     = '0;
		HTRANS    = htrans_idle;
		HWRITE    = 1'b0;
		HSIZE     = 3'd2;
		HWDATA    = '0;
		lcg_state = 32'he231_d2da;
		repeat (8) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		// Reset values and plain register access
		read_and_check(crc_pol_addr, "reset poly", 32'h04C1_1DB7);
		read_and_check(crc_init_addr, "reset init", 32'hFFFF_FFFF);
		read_and_check(crc_cr_addr, "reset control", 32'h0);
		read_and_check(crc_dr_addr, "reset crc", 32'hFFFF_FFFF);
		bus_write(crc_idr_addr, 32'hA5C3_1E77, 4);
		read_and_check(crc_idr_addr, "scratch byte", 32'h0000_0077);
		bus_write(crc_pol_addr, 32'h1234_5678, 4);
		read_and_check(crc_pol_addr, "poly readback", 32'h1234_5678);
		bus_write(crc_init_addr, 32'hDEAD_BEEF, 4);
		read_and_check(crc_init_addr, "init readback", 32'hDEAD_BEEF);

		// Plain CRC-32 over eight words
		set_mode(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 2'd0, 1'b0);
		for (int i = 0; i < 8; i++)
			data_write(random_word(), 4);
		read_and_check(crc_dr_addr, "crc32 words", expected_crc());

		// Narrow widths, bytes and halfwords mixed
		set_mode(32'h0000_1021, 32'h0000_FFFF, 2'd1, 2'd0, 1'b0);
		for (int i = 0; i < 6; i++)
			data_write(random_word(), (i % 2 == 0) ? 1 : 2);
		read_and_check(crc_dr_addr, "crc16 mixed", expected_crc());
		set_mode(32'h0000_0007, 32'h0000_0000, 2'd2, 2'd0, 1'b0);
		for (int i = 0; i < 6; i++)
			data_write(random_word(), (i % 2 == 0) ? 2 : 1);
		read_and_check(crc_dr_addr, "crc8 mixed", expected_crc());
		set_mode(32'h0000_0009, 32'h0000_007F, 2'd3, 2'd0, 1'b0);
		for (int i = 0; i < 6; i++)
			data_write(random_word(), (i % 2 == 0) ? 1 : 2);
		read_and_check(crc_dr_addr, "crc7 mixed", expected_crc());

		// Every input reversal mode with output reversal
		for (int m = 0; m < 4; m++)
		begin
			set_mode(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 2'(m), 1'b1);
			data_write(random_word(), 4);
			data_write(random_word(), 2);
			data_write(random_word(), 1);
			data_write(random_word(), 4);
			read_and_check(crc_dr_addr, $sformatf("reversal mode %0d", m), expected_crc());
		end
		// Reflected output right-aligned at 16 bits
		set_mode(32'h0000_8005, 32'h0000_0000, 2'd1, 2'd2, 1'b1);
		data_write(random_word(), 4);
		data_write(random_word(), 2);
		read_and_check(crc_dr_addr, "crc16 reflected", expected_crc());

		// Back-to-back writes stall on the buffer without losing data
		set_mode(32'h04C1_1DB7, 32'hFFFF_FFFF, 2'd0, 2'd0, 1'b0);
		burst_then_read(6, rdata);
		check_value("back-to-back", expected_crc(), rdata);

		// Restart from a new initial value
		set_mode(32'h04C1_1DB7, 32'h1D0F_5A3C, 2'd0, 2'd0, 1'b0);
		read_and_check(crc_dr_addr, "restart value", 32'h1D0F_5A3C);
		for (int i = 0; i < 4; i++)
			data_write(random_word(), 4);
		read_and_check(crc_dr_addr, "restart crc", expected_crc());

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/crc_pkg.sv
hdl/host_interface.sv
hdl/crc_input_buffer.sv
hdl/crc_engine.sv
hdl/crc_ahb.sv
tests/tb_crc_ahb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CRC peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_crc_ahb -o tb_crc_ahb

# The run passes only if the pass message shows up in the output
./obj_dir/tb_crc_ahb | tee /dev/stderr | grep -q "TEST OK"
